/* list.f */
hdl/mpr121_pkg.sv
hdl/i2c_byte_engine.sv
hdl/mpr121_sequencer.sv
hdl/mpr121_controller.sv
verification/mpr121_props.sv
verification/mpr121_slave_model.sv
verification/tb_mpr121.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_mpr121
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_mpr121.sv */
`timescale 1ns/1ps

module tb_mpr121;

	localparam int SEED = 59087;
	localparam int N_RANDOM = 20;
	localparam int N_XFERS = 2 + 2 * N_RANDOM + 3 + 2; // every transfer of the run
	localparam int XFER_NS = 40 * 4 * mpr121_pkg::SCL_QUARTER * 20; // 40 scl periods
	localparam int WATCHDOG_NS = (N_XFERS + 1) * XFER_NS; // one spare for reset
	localparam int HOLD_CYCLES = 8 * mpr121_pkg::SCL_QUARTER;
	// stop quarters left once sda has risen mid stop
	localparam int STOP_TAIL = 2 * mpr121_pkg::SCL_QUARTER;
	localparam int READ_TAIL = STOP_TAIL + 4;

	logic clk = 1'b0;
	logic rstn;
	logic wr_en;
	logic rd_en;
	logic [7:0] reg_addr;
	logic [7:0] wr_data;
	logic [7:0] rd_data;
	logic busy;
	logic fail;
	logic scl_low;
	logic sda_low_m; // master pull-down
	logic sda_low_s; // slave pull-down
	logic slave_nack;
	wire scl_line;
	wire sda_line;
	logic [7:0] mirror [0:255]; // expected sensor registers
	logic [7:0] addr_log [$];
	logic cur_read = 1'b0; // kind of current request
	int start_cnt = 0;
	int since_stop = 0;
	logic stop_seen = 1'b0;
	logic prev_scl = 1'b1;
	logic prev_sda = 1'b1;
	logic prev_busy = 1'b0;

	always #10 clk = ~clk; // 50 MHz

	assign scl_line = !scl_low;
	assign sda_line = !(sda_low_m || sda_low_s); // pulled-up wired-AND

	mpr121_controller u_dut (
		.i_CLK      (clk),
		.i_RSTN     (rstn),
		.i_wr_en    (wr_en),
		.i_rd_en    (rd_en),
		.i_reg_addr (reg_addr),
		.i_wr_data  (wr_data),
		.i_sda      (sda_line),
		.o_rd_data  (rd_data),
		.o_busy     (busy),
		.o_fail     (fail),
		.o_scl_low  (scl_low),
		.o_sda_low  (sda_low_m)
	);

	mpr121_slave_model u_slave (
		.i_scl        (scl_line),
		.i_sda        (sda_line),
		.i_force_nack (slave_nack),
		.o_sda_low    (sda_low_s)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
		assert (got == exp)
		else abort_run($sformatf("FAILED %s: expected %h, got %h", name, exp, got));
	endtask

	// one request through the enable/busy handshake
	task automatic do_transfer(input logic is_read, input logic [7:0] addr,
		input logic [7:0] data, input logic exp_fail);
		@(negedge clk);
		cur_read = is_read;
		reg_addr = addr;
		wr_data = data;
		wr_en = !is_read;
		rd_en = is_read;
		while (!busy)
			@(negedge clk);
		while (busy)
			@(negedge clk);
		check_byte("o_fail", {7'b0, exp_fail}, {7'b0, fail});
		if (is_read && !exp_fail)
			check_byte("o_rd_data", mirror[addr], rd_data);
		if (!is_read && !exp_fail)
			mirror[addr] = data; // last write wins
		check_byte("u_slave.regs", mirror[addr], u_slave.regs[addr]);
		wr_en = 1'b0;
		rd_en = 1'b0;
	endtask

	// ==================================================================
	// bus monitor for start count and stop to busy-low distance
	// ==================================================================
	always @(negedge clk)
	begin
		if (u_dut.u_props.n_fail != 0)
			abort_run("a bus or handshake property of the controller failed");
		if (scl_line && prev_scl && prev_sda && !sda_line)
			start_cnt++;
		if (scl_line && prev_scl && !prev_sda && sda_line)
		begin
			stop_seen = 1'b1;
			since_stop = 0;
		end
		else if (stop_seen)
			since_stop++;
		if (prev_busy && !busy && stop_seen && !fail)
		begin
			if (cur_read)
			begin
				assert (since_stop <= READ_TAIL)
				else abort_run("o_busy stayed high too long after a read stop");
			end
			else
			begin
				assert (since_stop >= STOP_TAIL + mpr121_pkg::WRITE_SETTLE)
				else abort_run("o_busy fell before the write settle time ran out");
			end
		end
		if (prev_busy && !busy)
			stop_seen = 1'b0;
		prev_scl = scl_line;
		prev_sda = sda_line;
		prev_busy = busy;
	end

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("watchdog timeout, transfers did not finish in time");
	end

	initial
	begin
		logic [7:0] addr;
		logic [7:0] data;
		int starts;
		void'($urandom(SEED));
		rstn = 1'b0;
		wr_en = 1'b0;
		rd_en = 1'b0;
		reg_addr = 8'h00;
		wr_data = 8'h00;
		slave_nack = 1'b0;
		for (int i = 0; i < 256; i++)
			mirror[8'(i)] = 8'(i) ^ 8'h5A; // sensor power-up pattern
		repeat (10)
			@(negedge clk);
		rstn = 1'b1;

		// single write then read back of a touch threshold reg
		do_transfer(1'b0, 8'h41, 8'hC3, 1'b0);
		do_transfer(1'b1, 8'h41, 8'h00, 1'b0);

		for (int k = 0; k < N_RANDOM; k++)
		begin
			addr = 8'($urandom());
			data = 8'($urandom());
			addr_log.push_back(addr);
			do_transfer(1'b0, addr, data, 1'b0);
		end
		foreach (addr_log[k])
			do_transfer(1'b1, addr_log[k], 8'h00, 1'b0);

		// nack on address leaves the reg alone
		slave_nack = 1'b1;
		do_transfer(1'b0, 8'h5E, ~mirror[8'h5E], 1'b1);
		slave_nack = 1'b0;
		do_transfer(1'b0, 8'h5E, 8'h8C, 1'b0);
		do_transfer(1'b1, 8'h5E, 8'h00, 1'b0);

		// enable held high past the end of a read
		@(negedge clk);
		cur_read = 1'b1;
		reg_addr = addr_log[0];
		rd_en = 1'b1;
		while (!busy)
			@(negedge clk);
		while (busy)
			@(negedge clk);
		starts = start_cnt;
		repeat (HOLD_CYCLES)
		begin
			@(negedge clk);
			assert (!busy && (start_cnt == starts))
			else abort_run("a new transfer started while the enable was still held");
		end
		rd_en = 1'b0;
		do_transfer(1'b1, addr_log[0], 8'h00, 1'b0); // dropped then raised again

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* verification/mpr121_slave_model.sv */
`timescale 1ns/1ps

module mpr121_slave_model (
	input  logic i_scl, // resolved scl
	input  logic i_sda, // resolved sda
	input  logic i_force_nack, // refuse every byte
	output logic o_sda_low
);

	logic [7:0] regs [0:255]; // sensor register file
	logic [7:0] shift; // byte in or out
	logic [7:0] ptr = 8'h00; // register pointer
	int bit_cnt = 0; // scl rises within byte, ack is the 9th
	int byte_idx = 0; // bytes since last start
	logic rx = 1'b0;
	logic tx = 1'b0;
	logic go_tx = 1'b0; // address+R acked
	logic master_nack = 1'b0;
	logic prev_scl = 1'b1;
	logic prev_sda = 1'b1;
	logic drive = 1'b0;
	mpr121_pkg::i2c_addr_byte_t addr_byte;

	assign o_sda_low = drive;

	initial
	begin
		for (int i = 0; i < 256; i++)
			regs[8'(i)] = 8'(i) ^ 8'h5A; // power-up pattern
	end

	// master byte complete, decide ack
	task automatic byte_in();
		logic ack;
		ack = !i_force_nack;
		if (byte_idx == 0)
		begin
			addr_byte.raw = shift;
			ack = ack && (addr_byte.f.addr == mpr121_pkg::MPR121_ADDR);
			go_tx = ack && addr_byte.f.rw;
		end
		else if (ack && (byte_idx == 1))
			ptr = shift; // command byte
		else if (ack)
		begin
			regs[ptr] = shift;
			ptr = ptr + 8'd1; // auto increment
		end
		if (!ack)
			rx = 1'b0; // deaf until next start
		drive = ack; // low through ack clock
	endtask

	// sda only ever moves here, under scl low
	task automatic scl_fall();
		if (bit_cnt == 9)
		begin
			bit_cnt = 0;
			byte_idx++;
			drive = 1'b0; // ack slot over
			if (rx && go_tx)
			begin
				rx = 1'b0;
				tx = 1'b1;
				go_tx = 1'b0;
			end
			else if (tx && master_nack)
				tx = 1'b0; // master done reading
			if (tx)
			begin
				shift = regs[ptr];
				ptr = ptr + 8'd1;
				drive = !shift[7]; // msb first
			end
		end
		else if ((bit_cnt == 8) && rx)
			byte_in();
		else if (tx && (bit_cnt > 0))
		begin
			shift = {shift[6:0], 1'b0};
			drive = (bit_cnt < 8) && !shift[7]; // release for master ack
		end
	endtask

	// ==================================================================
	// bus event decode
	// ==================================================================
	always @(posedge i_scl or negedge i_scl or posedge i_sda or negedge i_sda)
	begin
		if (i_scl && prev_scl && (i_sda != prev_sda))
		begin
			rx = !i_sda; // start or sr opens, stop closes
			tx = 1'b0;
			go_tx = 1'b0;
			bit_cnt = 0;
			byte_idx = 0;
			drive = 1'b0;
		end
		else if (i_scl && !prev_scl)
		begin
			if (rx && (bit_cnt < 8))
				shift = {shift[6:0], i_sda};
			else if (tx && (bit_cnt == 8))
				master_nack = i_sda;
			bit_cnt++;
		end
		else if (!i_scl && prev_scl)
			scl_fall();
		prev_scl = i_scl;
		prev_sda = i_sda;
	end

endmodule

/* verification/mpr121_props.sv */
`timescale 1ns/1ps

module mpr121_props (
	input logic i_CLK,
	input logic i_RSTN,
	input logic i_busy,
	input logic i_fail,
	input logic [7:0] i_rd_data,
	input logic i_scl_low, // master is the only scl driver
	input logic i_sda
);

	int n_fail = 0; // failed properties so far

	// ==================================================================
	// host side
	// ==================================================================
	a_idle_after_reset: assert property (@(posedge i_CLK) $rose(i_RSTN) |-> !i_busy)
	else
	begin
		n_fail++;
		$error("o_busy high as reset is released");
	end

	a_rd_data_stable: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_busy |-> $stable(i_rd_data)) // only updates as busy drops
	else
	begin
		n_fail++;
		$error("o_rd_data changed during a transfer");
	end

	a_no_fail_while_busy: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		!(i_fail && i_busy))
	else
	begin
		n_fail++;
		$error("o_fail and o_busy high together");
	end

	// ==================================================================
	// bus side
	// ==================================================================
	// sda edge under scl high is a start or stop and only happens in a transfer
	a_sda_quiet: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(!i_scl_low && !$past(i_scl_low) && (i_sda != $past(i_sda))) |-> i_busy)
	else
	begin
		n_fail++;
		$error("start or stop on the bus while idle");
	end

endmodule

bind mpr121_controller mpr121_props u_props (
	.i_CLK     (i_CLK),
	.i_RSTN    (i_RSTN),
	.i_busy    (o_busy),
	.i_fail    (o_fail),
	.i_rd_data (o_rd_data),
	.i_scl_low (o_scl_low),
	.i_sda     (i_sda)
);

/* hdl/mpr121_controller.sv */
`timescale 1ns/1ps

module mpr121_controller (
	input  logic i_CLK,
	input  logic i_RSTN,

	// host side, level enable against busy
	input  logic i_wr_en,
	input  logic i_rd_en,
	input  logic [7:0] i_reg_addr,
	input  logic [7:0] i_wr_data,
	output logic [7:0] o_rd_data,
	output logic o_busy,
	output logic o_fail,

	// i2c lines, open drain
	input  logic i_sda, // resolved sda
	output logic o_scl_low, // pull scl down
	output logic o_sda_low // pull sda down
);

	// ==================================================================
	// sequencer <-> engine
	// ==================================================================
	logic w_op_valid;
	logic [mpr121_pkg::OP_W-1:0] w_op_code;
	logic [7:0] w_op_byte;
	logic w_op_ready;
	logic w_op_done;
	logic [7:0] w_rd_byte; // byte shifted in
	logic w_ack_missed; // nack seen on last write

	mpr121_sequencer u_seq (
		.i_CLK        (i_CLK),
		.i_RSTN       (i_RSTN),
		.i_wr_en      (i_wr_en),
		.i_rd_en      (i_rd_en),
		.i_reg_addr   (i_reg_addr),
		.i_wr_data    (i_wr_data),
		.i_op_ready   (w_op_ready),
		.i_op_done    (w_op_done),
		.i_rd_byte    (w_rd_byte),
		.i_ack_missed (w_ack_missed),
		.o_op_valid   (w_op_valid),
		.o_op_code    (w_op_code),
		.o_op_byte    (w_op_byte),
		.o_rd_data    (o_rd_data),
		.o_busy       (o_busy),
		.o_fail       (o_fail)
	);

	i2c_byte_engine u_engine (
		.i_CLK        (i_CLK),
		.i_RSTN       (i_RSTN),
		.i_op_valid   (w_op_valid),
		.i_op_code    (w_op_code),
		.i_op_byte    (w_op_byte),
		.i_sda        (i_sda),
		.o_op_ready   (w_op_ready),
		.o_op_done    (w_op_done),
		.o_rd_byte    (w_rd_byte),
		.o_ack_missed (w_ack_missed),
		.o_scl_low    (o_scl_low),
		.o_sda_low    (o_sda_low)
	);

endmodule

/* hdl/mpr121_sequencer.sv */
`timescale 1ns/1ps

module mpr121_sequencer (
	input  logic i_CLK,
	input  logic i_RSTN,
	input  logic i_wr_en, // write has priority
	input  logic i_rd_en,
	input  logic [7:0] i_reg_addr,
	input  logic [7:0] i_wr_data,
	input  logic i_op_ready,
	input  logic i_op_done,
	input  logic [7:0] i_rd_byte,
	input  logic i_ack_missed,
	output logic o_op_valid,
	output logic [mpr121_pkg::OP_W-1:0] o_op_code,
	output logic [7:0] o_op_byte,
	output logic [7:0] o_rd_data,
	output logic o_busy,
	output logic o_fail
);

	logic [mpr121_pkg::SEQ_W-1:0] r_state;
	logic [mpr121_pkg::STEP_W-1:0] r_step; // index into op list
	logic r_is_read;
	logic r_fail_pend; // nack seen, heading for stop
	logic [mpr121_pkg::SETTLE_W-1:0] r_settle;
	logic [7:0] r_reg_addr; // latched request
	logic [7:0] r_wr_data;
	logic [7:0] r_rd_hold; // read byte until busy drops

	logic [mpr121_pkg::STEP_W-1:0] w_last_step;
	logic [mpr121_pkg::OP_W-1:0] w_code;
	logic [7:0] w_byte;
	mpr121_pkg::i2c_addr_byte_t w_addr_wr;
	mpr121_pkg::i2c_addr_byte_t w_addr_rd;

	assign w_last_step = r_is_read ? mpr121_pkg::RD_LAST_STEP : mpr121_pkg::WR_LAST_STEP;

	// ==================================================================
	// op list decode
	// write: S, addr+W, reg, data, P
	// read:  S, addr+W, reg, Sr, addr+R, read, P
	// ==================================================================
	always_comb
	begin
		w_addr_wr.f.addr = mpr121_pkg::MPR121_ADDR;
		w_addr_wr.f.rw = 1'b0;
		w_addr_rd.f.addr = mpr121_pkg::MPR121_ADDR;
		w_addr_rd.f.rw = 1'b1;
		w_code = mpr121_pkg::OP_STOP;
		w_byte = 8'h00; // don't care for start/stop/read
		case (r_step)
			3'd0: w_code = mpr121_pkg::OP_START;
			3'd1:
			begin
				w_code = mpr121_pkg::OP_WRITE;
				w_byte = w_addr_wr.raw;
			end
			3'd2:
			begin
				w_code = mpr121_pkg::OP_WRITE;
				w_byte = r_reg_addr; // command byte
			end
			3'd3:
			begin
				if (r_is_read)
					w_code = mpr121_pkg::OP_START; // becomes Sr in engine
				else
				begin
					w_code = mpr121_pkg::OP_WRITE;
					w_byte = r_wr_data;
				end
			end
			3'd4:
			begin
				if (r_is_read)
				begin
					w_code = mpr121_pkg::OP_WRITE;
					w_byte = w_addr_rd.raw;
				end
			end
			3'd5: w_code = mpr121_pkg::OP_READ; // read list only
			default: w_code = mpr121_pkg::OP_STOP;
		endcase
	end

	// request and read byte, no reset needed
	always_ff @(posedge i_CLK)
	begin
		if (r_state == mpr121_pkg::SEQ_IDLE)
		begin
			r_reg_addr <= i_reg_addr;
			r_wr_data <= i_wr_data;
		end
		if (i_op_done && (o_op_code == mpr121_pkg::OP_READ))
			r_rd_hold <= i_rd_byte;
	end

	// ==================================================================
	// transaction FSM
	// ==================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			r_state <= mpr121_pkg::SEQ_IDLE;
			r_step <= '0;
			r_is_read <= 1'b0;
			r_fail_pend <= 1'b0;
			r_settle <= '0;
			o_op_valid <= 1'b0;
			o_op_code <= mpr121_pkg::OP_STOP;
			o_op_byte <= 8'h00;
			o_rd_data <= 8'h00;
			o_busy <= 1'b0;
			o_fail <= 1'b0;
		end
		else
		begin
			o_op_valid <= 1'b0; // single-cycle strobe
			case (r_state)
				mpr121_pkg::SEQ_IDLE:
				begin
					if (i_wr_en || i_rd_en)
					begin
						r_is_read <= !i_wr_en;
						r_step <= '0;
						r_fail_pend <= 1'b0;
						o_busy <= 1'b1;
						o_fail <= 1'b0; // cleared on accept
						r_state <= mpr121_pkg::SEQ_ISSUE;
					end
				end
				mpr121_pkg::SEQ_ISSUE:
				begin
					if (i_op_ready)
					begin
						o_op_valid <= 1'b1;
						o_op_code <= w_code;
						o_op_byte <= w_byte;
						r_state <= mpr121_pkg::SEQ_WAIT;
					end
				end
				mpr121_pkg::SEQ_WAIT:
				begin
					if (i_op_done)
					begin
						if (o_op_code == mpr121_pkg::OP_STOP)
						begin
							if (!r_is_read && !r_fail_pend)
							begin
								r_settle <= '0;
								r_state <= mpr121_pkg::SEQ_SETTLE;
							end
							else
							begin
								o_busy <= 1'b0;
								o_fail <= r_fail_pend;
								if (r_is_read && !r_fail_pend)
									o_rd_data <= r_rd_hold;
								r_state <= mpr121_pkg::SEQ_HOLD;
							end
						end
						else if (i_ack_missed)
						begin
							// abort, jump straight to stop
							r_fail_pend <= 1'b1;
							r_step <= w_last_step;
							r_state <= mpr121_pkg::SEQ_ISSUE;
						end
						else
						begin
							r_step <= r_step + 1'b1;
							r_state <= mpr121_pkg::SEQ_ISSUE;
						end
					end
				end
				mpr121_pkg::SEQ_SETTLE:
				begin
					if (r_settle == mpr121_pkg::SETTLE_LAST)
					begin
						o_busy <= 1'b0;
						r_state <= mpr121_pkg::SEQ_HOLD;
					end
					else
						r_settle <= r_settle + 1'b1;
				end
				mpr121_pkg::SEQ_HOLD:
				begin
					if (!i_wr_en && !i_rd_en) // no restart on held enable
						r_state <= mpr121_pkg::SEQ_IDLE;
				end
				default: r_state <= mpr121_pkg::SEQ_IDLE;
			endcase
		end
	end

endmodule

/* hdl/i2c_byte_engine.sv */
`timescale 1ns/1ps

module i2c_byte_engine (
	input  logic i_CLK,
	input  logic i_RSTN,
	input  logic i_op_valid,
	input  logic [mpr121_pkg::OP_W-1:0] i_op_code,
	input  logic [7:0] i_op_byte,
	input  logic i_sda, // resolved line
	output logic o_op_ready,
	output logic o_op_done,
	output logic [7:0] o_rd_byte,
	output logic o_ack_missed,
	output logic o_scl_low,
	output logic o_sda_low
);

	logic r_active; // op in progress
	logic [mpr121_pkg::OP_W-1:0] r_code;
	logic [mpr121_pkg::PRESC_W-1:0] r_presc; // clocks within a quarter
	logic [5:0] r_phase; // quarter index within op
	logic r_owned; // we issued a start, no stop yet
	logic [7:0] r_shift;
	logic r_ready;
	logic r_done;
	logic r_ack_missed;
	logic r_scl_low;
	logic r_sda_low;

	logic w_accept;
	logic w_qstart; // first clock of a quarter
	logic w_qend; // last clock of a quarter
	logic w_is_byte;
	logic w_last;
	logic [3:0] w_bit; // 0..7 data, 8 ack
	logic [1:0] w_quarter;

	assign w_accept = i_op_valid && r_ready;
	assign w_qstart = r_active && (r_presc == '0);
	assign w_qend = r_active && (r_presc == mpr121_pkg::PRESC_LAST);
	assign w_is_byte = (r_code == mpr121_pkg::OP_WRITE) || (r_code == mpr121_pkg::OP_READ);
	assign w_last = w_is_byte ? (r_phase == 6'd35) : (r_phase == 6'd3); // 36 or 4 quarters
	assign w_bit = r_phase[5:2];
	assign w_quarter = r_phase[1:0];

	assign o_op_ready = r_ready;
	assign o_op_done = r_done;
	assign o_rd_byte = r_shift;
	assign o_ack_missed = r_ack_missed;
	assign o_scl_low = r_scl_low;
	assign o_sda_low = r_sda_low;

	// ==================================================================
	// shift register, MSB first both ways
	// ==================================================================
	always_ff @(posedge i_CLK)
	begin
		if (w_accept)
			r_shift <= i_op_byte;
		else if (w_qstart && w_is_byte && (w_quarter == 2'd2) && (w_bit != 4'd8))
			r_shift <= {r_shift[6:0], i_sda}; // mid scl high
	end

	// ==================================================================
	// quarter sequencing and line control
	// each bit: q0 set sda, q1 scl up, q2 sample, q3 scl down
	// ==================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			r_active <= 1'b0;
			r_code <= mpr121_pkg::OP_STOP;
			r_presc <= '0;
			r_phase <= '0;
			r_owned <= 1'b0;
			r_ready <= 1'b1;
			r_done <= 1'b0;
			r_ack_missed <= 1'b0;
			r_scl_low <= 1'b0; // both lines released
			r_sda_low <= 1'b0;
		end
		else
		begin
			r_done <= 1'b0;
			if (w_accept)
			begin
				r_active <= 1'b1;
				r_code <= i_op_code;
				r_ready <= 1'b0;
				r_ack_missed <= 1'b0;
				r_presc <= '0;
				r_phase <= '0;
			end
			else if (r_active)
			begin
				// prescaler and phase
				if (w_qend)
				begin
					r_presc <= '0;
					if (w_last)
					begin
						r_active <= 1'b0;
						r_ready <= 1'b1;
						r_done <= 1'b1;
					end
					else
						r_phase <= r_phase + 1'b1;
				end
				else
					r_presc <= r_presc + 1'b1;

				if (w_qstart)
				begin
					case (r_code)
						mpr121_pkg::OP_START:
						begin
							case (w_quarter)
								2'd0:
								begin
									if (r_owned)
										r_sda_low <= 1'b0; // sr setup, scl still low
								end
								2'd1: r_scl_low <= 1'b0;
								2'd2: r_sda_low <= 1'b1; // sda falls, scl high
								default:
								begin
									r_scl_low <= 1'b1;
									r_owned <= 1'b1;
								end
							endcase
						end
						mpr121_pkg::OP_STOP:
						begin
							// stop on an idle bus would glitch a start
							if (r_owned)
							begin
								case (w_quarter)
									2'd0: r_sda_low <= 1'b1; // sda low under scl low
									2'd1: r_scl_low <= 1'b0;
									2'd2: r_sda_low <= 1'b0; // sda rises, scl high
									default: r_owned <= 1'b0;
								endcase
							end
						end
						default:
						begin
							// write or read byte plus ack slot
							case (w_quarter)
								2'd0:
								begin
									// read and ack slot release sda (nack on read)
									r_sda_low <= (r_code == mpr121_pkg::OP_WRITE) &&
										(w_bit != 4'd8) && !r_shift[7];
								end
								2'd1: r_scl_low <= 1'b0;
								2'd2:
								begin
									if (w_bit == 4'd8)
										r_ack_missed <= (r_code == mpr121_pkg::OP_WRITE) && i_sda;
								end
								default: r_scl_low <= 1'b1;
							endcase
						end
					endcase
				end
			end
		end
	end

endmodule

/* hdl/mpr121_pkg.sv */
package mpr121_pkg;

	// ==================================================================
	// bus constants
	// ==================================================================
	localparam logic [6:0] MPR121_ADDR = 7'h5B; // ADDR pin tied to 3Vo
	localparam int SCL_QUARTER = 125; // 50 MHz / (4 * 100 kHz)
	localparam int PRESC_W = $clog2(SCL_QUARTER);
	localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(SCL_QUARTER - 1);
	localparam int WRITE_SETTLE = 125; // quiet time after a write stop
	localparam int SETTLE_W = $clog2(WRITE_SETTLE);
	localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(WRITE_SETTLE - 1);

	// ==================================================================
	// engine operations
	// ==================================================================
	localparam int OP_W = 2;
	localparam logic [OP_W-1:0] OP_START = 2'd0; // repeated start when bus owned
	localparam logic [OP_W-1:0] OP_WRITE = 2'd1; // byte out, slave ack in
	localparam logic [OP_W-1:0] OP_READ = 2'd2; // byte in, nack out
	localparam logic [OP_W-1:0] OP_STOP = 2'd3;

	// sequencer states and op list length
	localparam int SEQ_W = 3;
	localparam logic [SEQ_W-1:0] SEQ_IDLE = 3'd0;
	localparam logic [SEQ_W-1:0] SEQ_ISSUE = 3'd1; // hand next op to engine
	localparam logic [SEQ_W-1:0] SEQ_WAIT = 3'd2; // op on the bus
	localparam logic [SEQ_W-1:0] SEQ_SETTLE = 3'd3; // post-write delay
	localparam logic [SEQ_W-1:0] SEQ_HOLD = 3'd4; // wait for enable release
	localparam int STEP_W = 3;
	localparam logic [STEP_W-1:0] WR_LAST_STEP = 3'd4; // start, 3 bytes, stop
	localparam logic [STEP_W-1:0] RD_LAST_STEP = 3'd6; // start, 2 bytes, sr, addr, read, stop

	// address byte as sent on the wire, or as address plus r/w
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [6:0] addr;
			logic rw; // 1 = read
		} f;
	} i2c_addr_byte_t;

endpackage
